// ==== tb.f ====
src/pkt_buf_pkg.sv
src/line_ram_pipelined.sv
src/rd_line_counter.sv
src/rd_ctrl_fsm.sv
src/out_stage.sv
src/pkt_buffer_top.sv
testbench/pkt_buffer_assertions.sv
testbench/pkt_buffer_tb.sv

// ==== testbench/pkt_buffer_tb.sv ====
/*
  testbench for the packet line buffer, LFSR stimulus, reference line memory,
  output line checks against expected queue, per-test report and watchdog
*/
`timescale 1ns/1ps

module pkt_buffer_tb import pkt_buf_pkg::*; ();

  localparam int RAM_PIPELINE = 3;
  localparam int CLK_PERIOD   = 40;
  localparam logic [31:0] SEED = 32'h808a_49b5;

  // lines written, lines read and reset cycles over all tests
  localparam int TEST_LEN   = 268 + 159 + 12;
  localparam int TIMEOUT_NS = TEST_LEN * (RAM_PIPELINE + 4) * CLK_PERIOD;

  logic     clk;
  logic     rst;
  logic     wr_en;
  strb_t    wr_strb;
  addr_t    wr_addr;
  line_t    wr_data;
  logic     rd_req;
  rd_desc_t rd_desc;
  logic     rd_busy;
  logic     out_valid;
  pkt_out_t pkt_out;

  // reference memory, mirrors every strobed write
  line_t    ref_mem [2**ADDR_W];
  // lines still owed by the DUT, oldest first
  pkt_out_t exp_q [$];

  logic [31:0] lfsr;
  string       test_name;
  int          err_cnt    = 0;
  int          err_start  = 0;
  int          test_cnt   = 0;
  int          fail_tests = 0;
  int          acc_cnt    = 0;
  int          acc_start  = 0;

  pkt_buffer_top #(
    .RAM_PIPELINE (RAM_PIPELINE)
  ) i_dut (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_strb   (wr_strb),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_req    (rd_req),
    .rd_desc   (rd_desc),
    .rd_busy   (rd_busy),
    .out_valid (out_valid),
    .pkt_out   (pkt_out)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // bytes below len mod 4 are kept, zero tail keeps the whole line
  function automatic strb_t keep_for(input len_t len);
    int    tail;
    strb_t k;
    tail = len % LINE_BYTES;
    for (int b = 0; b < LINE_BYTES; b++)
      k[b] = (tail == 0) || (b < tail);
    return k;
  endfunction

  function automatic line_t mask_bytes(input line_t d, input strb_t k);
    line_t m;
    for (int b = 0; b < LINE_BYTES; b++)
      m[b*8 +: 8] = k[b] ? d[b*8 +: 8] : 8'h00;
    return m;
  endfunction

  function automatic int total_errors();
    return err_cnt + i_dut.i_assertions.fail_cnt;
  endfunction

  // expected lines of one accepted descriptor
  task automatic queue_packet(input rd_desc_t d);
    int       n;
    addr_t    a;
    pkt_out_t p;
    n = (d.len + LINE_BYTES - 1) / LINE_BYTES;
    a = d.start;
    for (int i = 0; i < n; i++) begin
      p.last = (i == n - 1);
      p.keep = p.last ? keep_for(d.len) : '1;
      p.data = mask_bytes(ref_mem[a], p.keep);
      exp_q.push_back(p);
      a = a + addr_t'(1);
    end
  endtask

  // inputs and outputs are all stable at the falling edge
  always @(negedge clk) begin
    pkt_out_t exp;
    if (!rst) begin
      if (wr_en) begin
        for (int b = 0; b < LINE_BYTES; b++)
          if (wr_strb[b])
            ref_mem[wr_addr][b*8 +: 8] = wr_data[b*8 +: 8];
      end
      if (rd_req && !rd_busy) begin
        acc_cnt++;
        queue_packet(rd_desc);
      end
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("%s: output line seen with no read pending", test_name);
          err_cnt++;
        end else begin
          exp = exp_q.pop_front();
          assert (pkt_out == exp) else begin
            $display("** Error %s: expected %h, actual %h", test_name, exp, pkt_out);
            err_cnt++;
          end
        end
      end
    end
  end

  task automatic write_line(input addr_t a, input strb_t s, input line_t d);
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_addr <= a;
    wr_strb <= s;
    wr_data <= d;
  endtask

  task automatic write_done();
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  // single-cycle request pulse
  task automatic request(input addr_t s, input len_t l);
    @(posedge clk);
    rd_req        <= 1'b1;
    rd_desc.start <= s;
    rd_desc.len   <= l;
    @(posedge clk);
    rd_req <= 1'b0;
  endtask

  task automatic wait_idle();
    do @(negedge clk); while (rd_busy || exp_q.size() != 0);
  endtask

  task automatic read_packet(input addr_t s, input len_t l);
    request(s, l);
    wait_idle();
  endtask

  task automatic end_test();
    int errs;
    errs = total_errors() - err_start;
    test_cnt++;
    if (errs == 0) begin
      $display("%-12s ok", test_name);
    end else begin
      $display("%-12s FAILED, %0d errors", test_name, errs);
      fail_tests++;
    end
    err_start = total_errors();
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout, run still going after %0d ns", TIMEOUT_NS);
    $display("test failed");
    $finish;
  end

  initial begin
    lfsr    = SEED;
    rst     = 1'b1;
    wr_en   = 1'b0;
    wr_strb = '0;
    wr_addr = '0;
    wr_data = '0;
    rd_req  = 1'b0;
    rd_desc = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    test_name = "reset";
    repeat (4) begin
      @(negedge clk);
      assert (!rd_busy && !out_valid) else begin
        $display("%s: busy or valid high after reset release", test_name);
        err_cnt++;
      end
    end
    end_test();

    // fill every line, then random descriptors plus one past line 255
    test_name = "readback";
    for (int i = 0; i < 2**ADDR_W; i++)
      write_line(addr_t'(i), '1, rand_bits(32));
    write_done();
    for (int i = 0; i < 6; i++)
      read_packet(addr_t'(rand_bits(8)), len_t'(rand_bits(6) + 1));
    read_packet(8'd250, 11'd40);
    end_test();

    // overlapping strobes, each byte ends with its latest writer
    test_name = "byte_merge";
    for (int pass = 0; pass < 3; pass++)
      for (int i = 16; i < 20; i++)
        write_line(addr_t'(i), strb_t'(4'b0011 << pass), rand_bits(32));
    write_done();
    read_packet(8'd16, 11'd16);
    end_test();

    test_name = "len_mask";
    read_packet(8'd100, 11'd1);
    read_packet(8'd100, 11'd4);
    read_packet(8'd100, 11'd5);
    read_packet(8'd100, 11'd7);
    read_packet(8'd100, 11'd32);
    end_test();

    test_name = "latency";
    read_packet(8'd40, 11'd48);
    end_test();

    // pulses while busy are dropped, the one as busy drops is taken
    test_name = "ignored_req";
    acc_start = acc_cnt;
    request(8'd60, 11'd80);
    repeat (3) begin
      repeat (2) @(posedge clk);
      request(8'd0, 11'd16);
    end
    do @(negedge clk); while (!(out_valid && pkt_out.last));
    request(8'd200, 11'd12);
    wait_idle();
    assert (acc_cnt - acc_start == 2) else begin
      $display("%s: wrong number of requests accepted", test_name);
      err_cnt++;
    end
    end_test();

    $display("summary: %0d tests, %0d failing, %0d errors", test_cnt, fail_tests,
             total_errors());
    if (fail_tests == 0 && total_errors() == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// ==== testbench/pkt_buffer_assertions.sv ====
/*
  bound checks for the packet buffer, shadow memory from the write port,
  output data, keep, last, latency and busy timing
*/
`timescale 1ns/1ps

module pkt_buffer_assertions import pkt_buf_pkg::*; #(
  parameter int RAM_PIPELINE = 2
) (
  input logic     clk,
  input logic     rst,
  input logic     wr_en,
  input strb_t    wr_strb,
  input addr_t    wr_addr,
  input line_t    wr_data,
  input logic     rd_req,
  input rd_desc_t rd_desc,
  input logic     rd_busy,
  input logic     out_valid,
  input pkt_out_t pkt_out
);

  line_t shadow [2**ADDR_W];
  addr_t next_addr;
  len_t  cur_len;
  int    lines_out;
  int    lines_needed;
  logic  is_last;
  strb_t exp_keep;
  line_t exp_data;
  logic  accept;
  int    fail_cnt = 0;

  assign accept = rd_req && !rd_busy;

  // shadow store plus position within the current packet
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < LINE_BYTES; b++)
        if (wr_strb[b])
          shadow[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
    end
    if (accept) begin
      next_addr <= rd_desc.start;
      cur_len   <= rd_desc.len;
      lines_out <= 0;
    end else if (out_valid) begin
      next_addr <= next_addr + addr_t'(1);
      lines_out <= lines_out + 1;
    end
  end

  always_comb begin
    lines_needed = (int'(cur_len) + LINE_BYTES - 1) / LINE_BYTES;
    // final line of the packet, counted from the accepted length
    is_last = (lines_out == lines_needed - 1);
    for (int b = 0; b < LINE_BYTES; b++)
      exp_keep[b] = !is_last || (cur_len % LINE_BYTES == 0) || (b < cur_len % LINE_BYTES);
    for (int b = 0; b < LINE_BYTES; b++)
      exp_data[b*8 +: 8] = exp_keep[b] ? shadow[next_addr][b*8 +: 8] : 8'h00;
  end

  a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !rd_busy && !out_valid)
    else begin $error("busy or valid high as reset ends"); fail_cnt++; end

  // first line exactly RAM_PIPELINE+2 cycles after the accepting cycle
  a_latency: assert property (@(posedge clk) disable iff (rst)
    accept |-> !out_valid [*RAM_PIPELINE+2] ##1 out_valid)
    else begin $error("first line not on time after accept"); fail_cnt++; end

  a_no_gap: assert property (@(posedge clk) disable iff (rst)
    out_valid && !pkt_out.last |=> out_valid)
    else begin $error("gap in output lines before last"); fail_cnt++; end

  a_busy_rise: assert property (@(posedge clk) disable iff (rst) accept |=> rd_busy)
    else begin $error("busy not raised after accept"); fail_cnt++; end

  a_busy_fall: assert property (@(posedge clk) disable iff (rst)
    out_valid && pkt_out.last |=> !rd_busy)
    else begin $error("busy still high after last line"); fail_cnt++; end

  a_keep: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> pkt_out.keep == exp_keep)
    else begin $error("keep mask does not follow length"); fail_cnt++; end

  a_data: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> pkt_out.data == exp_data)
    else begin $error("output data differs from shadow memory"); fail_cnt++; end

  a_last: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> pkt_out.last == is_last)
    else begin $error("last flag not on the final line"); fail_cnt++; end

endmodule

bind pkt_buffer_top pkt_buffer_assertions #(
  .RAM_PIPELINE (RAM_PIPELINE)
) i_assertions (
  .clk       (clk),
  .rst       (rst),
  .wr_en     (wr_en),
  .wr_strb   (wr_strb),
  .wr_addr   (wr_addr),
  .wr_data   (wr_data),
  .rd_req    (rd_req),
  .rd_desc   (rd_desc),
  .rd_busy   (rd_busy),
  .out_valid (out_valid),
  .pkt_out   (pkt_out)
);

// ==== src/pkt_buffer_top.sv ====
/*
  packet line buffer top, read FSM, line counter,
  pipelined line RAM and output stage
*/
`timescale 1ns/1ps

module pkt_buffer_top import pkt_buf_pkg::*; #(
  parameter int RAM_PIPELINE = 2
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     wr_en,
  input  strb_t    wr_strb,
  input  addr_t    wr_addr,
  input  line_t    wr_data,
  input  logic     rd_req,
  input  rd_desc_t rd_desc,
  output logic     rd_busy,
  output logic     out_valid,
  output pkt_out_t pkt_out
);

  // FSM to counter
  logic  load;
  addr_t start;
  len_t  lines;
  logic  step;

  // counter to FSM and RAM
  addr_t rd_addr;
  logic  last_line;

  // FSM to RAM
  logic    rd_en;
  rd_tag_t rd_tag;

  // RAM to output stage
  logic    ram_valid;
  line_t   ram_data;
  rd_tag_t ram_tag;

  rd_ctrl_fsm i_rd_ctrl_fsm (
    .clk       (clk),
    .rst       (rst),
    .rd_req    (rd_req),
    .rd_desc   (rd_desc),
    .last_line (last_line),
    .out_valid (out_valid),
    .out_last  (pkt_out.last),
    .rd_busy   (rd_busy),
    .load      (load),
    .start     (start),
    .lines     (lines),
    .step      (step),
    .rd_en     (rd_en),
    .rd_tag    (rd_tag)
  );

  rd_line_counter i_rd_line_counter (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .start     (start),
    .lines     (lines),
    .step      (step),
    .rd_addr   (rd_addr),
    .last_line (last_line)
  );

  line_ram_pipelined #(
    .RAM_PIPELINE (RAM_PIPELINE)
  ) i_line_ram_pipelined (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .wr_strb   (wr_strb),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_tag    (rd_tag),
    .ram_valid (ram_valid),
    .ram_data  (ram_data),
    .ram_tag   (ram_tag)
  );

  out_stage i_out_stage (
    .clk       (clk),
    .rst       (rst),
    .ram_valid (ram_valid),
    .ram_data  (ram_data),
    .ram_tag   (ram_tag),
    .out_valid (out_valid),
    .pkt_out   (pkt_out)
  );

endmodule

// ==== src/out_stage.sv ====
/*
  output register, zeroes bytes outside the keep mask
  and drives valid, last and keep
*/
`timescale 1ns/1ps

module out_stage import pkt_buf_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     ram_valid,
  input  line_t    ram_data,
  input  rd_tag_t  ram_tag,
  output logic     out_valid,
  output pkt_out_t pkt_out
);

  // data after masking
  line_t masked;

  // bytes past the packet end never leave with stale contents
  always_comb begin
    for (int b = 0; b < LINE_BYTES; b++)
      masked[b*8 +: 8] = ram_tag.keep[b] ? ram_data[b*8 +: 8] : 8'h00;
  end

  // valid is control, reset
  always_ff @(posedge clk) begin
    if (rst)
      out_valid <= 1'b0;
    else
      out_valid <= ram_valid;
  end

  // payload only updates with a real line
  always_ff @(posedge clk) begin
    if (ram_valid) begin
      pkt_out.data <= masked;
      pkt_out.keep <= ram_tag.keep;
      pkt_out.last <= ram_tag.last;
    end
  end

endmodule

// ==== src/rd_ctrl_fsm.sv ====
/*
  read control FSM, accepts descriptors while idle, drives the line counter,
  issues tagged reads and holds busy until the last line has left
*/
`timescale 1ns/1ps

module rd_ctrl_fsm import pkt_buf_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     rd_req,
  input  rd_desc_t rd_desc,
  input  logic     last_line,
  input  logic     out_valid,
  input  logic     out_last,
  output logic     rd_busy,
  output logic     load,
  output addr_t    start,
  output len_t     lines,
  output logic     step,
  output logic     rd_en,
  output rd_tag_t  rd_tag
);

  rd_state_t state_q;
  rd_state_t state_next;

  // keep mask for the final line of the current packet
  strb_t last_keep_q;
  strb_t last_keep;

  logic accept;

  // low bits of the length give the used bytes of the final line
  logic [OFS_W-1:0] tail;

  // requests seen while busy are dropped
  assign accept = rd_req && !rd_busy;

  assign tail = rd_desc.len[OFS_W-1:0];

  // zero tail means a full final line
  always_comb begin
    if (tail == '0)
      last_keep = '1;
    else
      last_keep = strb_t'((1 << tail) - 1);
  end

  // counter is loaded in the accepting cycle
  assign load  = accept;
  assign start = rd_desc.start;

  // round up to whole lines, one extra bit avoids overflow
  assign lines = len_t'(({1'b0, rd_desc.len} + (LINE_BYTES - 1)) >> OFS_W);

  // state register
  always_ff @(posedge clk) begin
    if (rst)
      state_q <= RD_IDLE;
    else
      state_q <= state_next;
  end

  // mask is only needed for the accepted packet
  always_ff @(posedge clk) begin
    if (accept)
      last_keep_q <= last_keep;
  end

  always_comb begin
    state_next = state_q;
    case (state_q)
      RD_IDLE: begin
        if (accept)
          state_next = RD_ISSUE;
      end
      RD_ISSUE: begin
        // final read goes out this cycle
        if (last_line)
          state_next = RD_DRAIN;
      end
      RD_DRAIN: begin
        // wait for the tagged line to reach the output
        if (out_valid && out_last)
          state_next = RD_IDLE;
      end
      default: state_next = RD_IDLE;
    endcase
  end

  assign rd_busy = (state_q != RD_IDLE);

  // one read and one counter step per cycle while issuing
  assign rd_en = (state_q == RD_ISSUE);
  assign step  = rd_en;

  assign rd_tag.last = last_line;
  assign rd_tag.keep = last_line ? last_keep_q : '1;

endmodule

// ==== src/rd_line_counter.sv ====
/*
  read line counter, loads start address and line count,
  steps the address with wrap and flags the final line
*/
`timescale 1ns/1ps

module rd_line_counter import pkt_buf_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  load,
  input  addr_t start,
  input  len_t  lines,
  input  logic  step,
  output addr_t rd_addr,
  output logic  last_line
);

  // current line address
  addr_t addr_q;

  // lines still to be read, including the current one
  len_t remain_q;

  // address register
  always_ff @(posedge clk) begin
    if (load) begin
      addr_q <= start;
    end else if (step) begin
      // wraps past the top line back to 0
      addr_q <= addr_q + addr_t'(1);
    end
  end

  // remaining count
  always_ff @(posedge clk) begin
    if (rst) begin
      remain_q <= '0;
    end else if (load) begin
      remain_q <= lines;
    end else if (step && remain_q != '0) begin
      remain_q <= remain_q - len_t'(1);
    end
  end

  assign rd_addr = addr_q;

  // one left means the address on rd_addr is the final line
  assign last_line = (remain_q == len_t'(1));

endmodule

// ==== src/line_ram_pipelined.sv ====
/*
  block RAM line store, byte strobed write port,
  registered read followed by a valid-gated output pipeline with tag
*/
`timescale 1ns/1ps

module line_ram_pipelined import pkt_buf_pkg::*; #(
  parameter int RAM_PIPELINE = 2
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    wr_en,
  input  strb_t   wr_strb,
  input  addr_t   wr_addr,
  input  line_t   wr_data,
  input  logic    rd_en,
  input  addr_t   rd_addr,
  input  rd_tag_t rd_tag,
  output logic    ram_valid,
  output line_t   ram_data,
  output rd_tag_t ram_tag
);

  // storage array, one entry per line address
  line_t mem [2**ADDR_W];

  // read pipeline, stage 0 is the RAM output register
  line_t             data_q [RAM_PIPELINE];
  rd_tag_t           tag_q  [RAM_PIPELINE];
  logic [RAM_PIPELINE-1:0] valid_q;

  // byte-wise write, untouched bytes keep their old value
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < LINE_BYTES; b++) begin
        if (wr_strb[b])
          mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
      end
    end
  end

  // registered read, tag captured in the same cycle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      data_q[0] <= mem[rd_addr];
      tag_q[0]  <= rd_tag;
    end
  end

  // later stages only move when the stage before holds a line
  always_ff @(posedge clk) begin
    for (int i = 1; i < RAM_PIPELINE; i++) begin
      if (valid_q[i-1]) begin
        data_q[i] <= data_q[i-1];
        tag_q[i]  <= tag_q[i-1];
      end
    end
  end

  // valid chain
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= rd_en;
      for (int i = 1; i < RAM_PIPELINE; i++)
        valid_q[i] <= valid_q[i-1];
    end
  end

  assign ram_valid = valid_q[RAM_PIPELINE-1];
  assign ram_data  = data_q[RAM_PIPELINE-1];
  assign ram_tag   = tag_q[RAM_PIPELINE-1];

endmodule

// ==== src/pkt_buf_pkg.sv ====
/*
  shared widths, vector typedefs, descriptor, read tag and output structs,
  and the read FSM state encoding
*/
package pkt_buf_pkg;

  // line geometry
  localparam int LINE_BYTES = 4;
  localparam int LINE_W     = LINE_BYTES * 8;

  // 256 lines of storage
  localparam int ADDR_W = 8;

  // byte length, up to 1024 bytes per descriptor
  localparam int LEN_W = 11;

  // byte offset bits within a line
  localparam int OFS_W = $clog2(LINE_BYTES);

  typedef logic [LINE_W-1:0]     line_t;
  typedef logic [LINE_BYTES-1:0] strb_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [LEN_W-1:0]      len_t;

  // read request, start line plus length in bytes
  typedef struct packed {
    addr_t start;
    len_t  len;
  } rd_desc_t;

  // sideband carried beside the read data
  typedef struct packed {
    logic  last;
    strb_t keep;
  } rd_tag_t;

  // one output line
  typedef struct packed {
    line_t data;
    strb_t keep;
    logic  last;
  } pkt_out_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ISSUE,
    RD_DRAIN
  } rd_state_t;

endpackage
